// ==== verilog.f ====
+incdir+include
verilog/gb_pkg.sv
verilog/gb_spram.sv
verilog/gb_bus_decode.sv
verilog/gb_irq_ctrl.sv
verilog/gb_joypad.sv
verilog/gb_serial.sv
verilog/gb_work_ram.sv
verilog/gb_system.sv
test/tb_gb_system.sv

// ==== Bender.yml ====
package:
  name: gb_system

export_include_dirs:
  - include

sources:
  - verilog/gb_pkg.sv
  - verilog/gb_spram.sv
  - verilog/gb_bus_decode.sv
  - verilog/gb_irq_ctrl.sv
  - verilog/gb_joypad.sv
  - verilog/gb_serial.sv
  - verilog/gb_work_ram.sv
  - verilog/gb_system.sv
  - target: test
    files:
      - test/tb_gb_system.sv

// ==== test/tb_gb_system.sv ====
// directed testbench for the system top with cpu bus model, value check and test tasks
`timescale 1ns/100ps
`include "gb_defs.svh"

module tb_gb_system import gb_pkg::*;;

	logic       clk, reset, cgb_mode;
	gb_addr_t   cpu_addr;
	gb_data_t   cpu_do;
	logic       cpu_rd_n, cpu_wr_n, cpu_m1_n, cpu_iorq_n;
	logic [7:0] joystick;
	logic       vblank_irq, lcd_irq, timer_irq;
	gb_data_t   cart_do;
	gb_data_t   cpu_di;
	logic       irq_n;
	gb_addr_t   cart_addr;
	gb_data_t   cart_di;
	logic       cart_rd, cart_wr;

	integer     seed;
	logic       rd_strobe;  // cart_rd seen by last read
	gb_addr_t   rd_addr;    // cart_addr seen by last read
	logic       wr_strobe;  // cart_wr seen by last write
	gb_data_t   wr_bus;     // cart_di seen by last write

	gb_system UUT (
		.clk (clk), .reset (reset), .cgb_mode (cgb_mode), .cpu_addr (cpu_addr),
		.cpu_do (cpu_do), .cpu_rd_n (cpu_rd_n), .cpu_wr_n (cpu_wr_n),
		.cpu_m1_n (cpu_m1_n), .cpu_iorq_n (cpu_iorq_n), .joystick (joystick),
		.vblank_irq (vblank_irq), .lcd_irq (lcd_irq), .timer_irq (timer_irq),
		.cart_do (cart_do), .cpu_di (cpu_di), .irq_n (irq_n), .cart_addr (cart_addr),
		.cart_di (cart_di), .cart_rd (cart_rd), .cart_wr (cart_wr)
	);

	always #5 clk = ~clk; // 100 MHz

	// ------------------------------
	// reporting
	// ------------------------------
	task automatic fail_now();
		$display("Something failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("** Error: %s is %h, expected %h", name, got, exp);
			fail_now();
		end
	endtask

	// ------------------------------
	// cpu bus model
	// ------------------------------
	task automatic bus_write(input gb_addr_t addr, input gb_data_t data);
		@(posedge clk);
		#1;
		cpu_addr = addr;
		cpu_do   = data;
		cpu_rd_n = 1'b1;
		cpu_wr_n = 1'b0;
		#2;                 // decode settles
		wr_strobe = cart_wr;
		wr_bus    = cart_di;
		@(posedge clk);     // write edge
		#1;
		cpu_wr_n = 1'b1;
	endtask

	// address held two cycles to cover the ram latency
	task automatic bus_read(input gb_addr_t addr, output gb_data_t data);
		@(posedge clk);
		#1;
		cpu_addr = addr;
		cpu_rd_n = 1'b0;
		cpu_wr_n = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		data      = cpu_di;
		rd_strobe = cart_rd;
		rd_addr   = cart_addr;
		cpu_rd_n  = 1'b1;
	endtask

	task automatic ack_cycle(output gb_data_t vec);
		@(posedge clk);
		#1;
		cpu_m1_n   = 1'b0;
		cpu_iorq_n = 1'b0;
		@(posedge clk);
		#1;
		vec        = cpu_di; // vector while ack held
		cpu_m1_n   = 1'b1;
		cpu_iorq_n = 1'b1;   // flag clears on this fall
	endtask

	// ------------------------------
	// tests
	// ------------------------------
	task automatic cart_and_ram_access();
		gb_data_t d, wdata, zdata;
		cart_do = 8'($random(seed));
		bus_read(16'h0150, d);                 // rom
		check("cpu_di rom", d, cart_do);
		check("cart_rd rom", 8'(rd_strobe), 8'h01);
		check("cart_addr rom", rd_addr, 16'h0150);
		cart_do = 8'($random(seed));
		bus_read(16'ha010, d);                 // cart ram
		check("cpu_di cram", d, cart_do);
		check("cart_rd cram", 8'(rd_strobe), 8'h01);
		check("cart_addr cram", rd_addr, 16'ha010);
		wdata = 8'($random(seed));
		bus_write(16'ha010, wdata);
		check("cart_wr", 8'(wr_strobe), 8'h01);
		check("cart_di", wr_bus, wdata);
		wdata = 8'($random(seed));
		zdata = 8'($random(seed));
		bus_write(16'hc123, wdata);
		bus_write(16'hff90, zdata);
		bus_read(16'hc123, d);
		check("cpu_di wram", d, wdata);
		check("cart_rd wram", 8'(rd_strobe), 8'h00); // internal ram leaves the cart quiet
		bus_read(16'hff90, d);
		check("cpu_di zpram", d, zdata);
		bus_read(`GB_ADDR_SB, d);
		check("cpu_di sb", d, 8'hff);
		bus_read(16'hff4c, d);                 // unmapped
		check("cpu_di unmapped", d, 8'hff);
		bus_read(`GB_ADDR_SVBK, d);
		check("cpu_di svbk", d, 8'hff);
	endtask

	task automatic wram_bank_switch();
		gb_data_t d, b1, b2, b3;
		b2 = 8'($random(seed));
		b3 = b2 ^ 8'h5a; // distinct per bank
		b1 = b2 ^ 8'ha5;
		cgb_mode = 1'b1;
		bus_write(`GB_ADDR_SVBK, 8'h02);
		bus_write(16'hd000, b2);
		bus_write(`GB_ADDR_SVBK, 8'h03);
		bus_write(16'hd000, b3);
		bus_write(`GB_ADDR_SVBK, 8'h02);
		bus_read(16'hd000, d);
		check("cpu_di bank 2", d, b2);
		bus_write(`GB_ADDR_SVBK, 8'h03);
		bus_read(16'hd000, d);
		check("cpu_di bank 3", d, b3);
		// 0 maps to bank 1
		bus_write(`GB_ADDR_SVBK, 8'h00);
		bus_write(16'hd000, b1);
		bus_write(`GB_ADDR_SVBK, 8'h01);
		bus_read(16'hd000, d);
		check("cpu_di bank 1", d, b1);
		bus_write(`GB_ADDR_SVBK, 8'h02);
		bus_read(16'hd000, d);
		check("cpu_di bank 2 again", d, b2);
		cgb_mode = 1'b0;
		bus_write(`GB_ADDR_SVBK, 8'h03);       // ignored in dmg mode
		bus_read(16'hd000, d);
		check("cpu_di dmg svbk", d, b2);
	endtask

	task automatic joypad_press();
		gb_data_t d;
		int       n;
		bus_write(`GB_ADDR_JOYP, 8'h20);       // P14 low selects directions
		@(posedge clk);
		#1;
		joystick = 8'h50;                      // buttons of the deselected group
		bus_read(`GB_ADDR_JOYP, d);
		check("joyp idle", d, {2'b11, 2'b10, 4'hf});
		@(posedge clk);
		#1;
		joystick = 8'h56;                      // left and up pressed
		bus_read(`GB_ADDR_JOYP, d);
		check("joyp pressed", d, {2'b11, 2'b10, 4'b1001});
		n = 0;
		bus_read(`GB_ADDR_IF, d);
		while (!d[4] && n < 20) begin
			bus_read(`GB_ADDR_IF, d);
			n++;
		end
		if (!d[4]) begin
			$display("joypad press never set the joypad interrupt flag");
			fail_now();
		end
		@(posedge clk);
		#1;
		joystick = 8'h00;                      // release makes the lines rise
		bus_write(`GB_ADDR_IF, 8'h00);
	endtask

	task automatic irq_priority_ack();
		gb_data_t d;
		int       n;
		bus_write(`GB_ADDR_IF, 8'h00);
		bus_write(`GB_ADDR_IE, 8'h1f);
		bus_read(`GB_ADDR_IE, d);
		check("ie", d, 8'h1f);
		@(posedge clk);
		#1;
		timer_irq = 1'b1;
		lcd_irq   = 1'b1;
		@(posedge clk);
		#1;
		timer_irq = 1'b0;
		lcd_irq   = 1'b0;
		n = 0;
		while (irq_n && n < 10) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (irq_n) begin
			$display("irq_n stayed high after timer and lcd pulses");
			fail_now();
		end
		ack_cycle(d);
		check("vector lcd", d, 8'h48);         // lcd ranks above timer
		bus_read(`GB_ADDR_IF, d);
		check("if after lcd ack", d, 8'he4);
		ack_cycle(d);
		check("vector timer", d, 8'h50);
		bus_read(`GB_ADDR_IF, d);
		check("if after timer ack", d, 8'he0);
		check("irq_n idle", 8'(irq_n), 8'h01);
		ack_cycle(d);
		check("vector none", d, 8'h55);
	endtask

	task automatic serial_transfer();
		gb_data_t d;
		int       n;
		bus_write(`GB_ADDR_IF, 8'h00);
		bus_write(`GB_ADDR_SC, 8'h81);         // start with internal clock
		bus_read(`GB_ADDR_SC, d);
		check("sc busy", d, 8'hff);
		n = 0;
		while (d[7] && n < 2000) begin         // 3 cycles per poll
			bus_read(`GB_ADDR_SC, d);
			n++;
		end
		if (d[7]) begin
			$display("serial transfer did not finish within 6000 cycles");
			fail_now();
		end
		check("sc done", d, 8'h7f);
		bus_read(`GB_ADDR_IF, d);
		check("if serial bit", d & 8'h08, 8'h08);
		bus_write(`GB_ADDR_SC, 8'h80);         // external clock never ends the transfer
		repeat (6000) @(posedge clk);
		bus_read(`GB_ADDR_SC, d);
		check("sc external", d, 8'hfe);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		seed       = 32'h1b7;
		clk        = 1'b0;
		reset      = 1'b1;
		cgb_mode   = 1'b0;
		cpu_addr   = '0;
		cpu_do     = '0;
		cpu_rd_n   = 1'b1;
		cpu_wr_n   = 1'b1;
		cpu_m1_n   = 1'b1;
		cpu_iorq_n = 1'b1;
		joystick   = '0;
		vblank_irq = 1'b0;
		lcd_irq    = 1'b0;
		timer_irq  = 1'b0;
		cart_do    = '0;
		rd_strobe  = 1'b0;
		rd_addr    = '0;
		wr_strobe  = 1'b0;
		wr_bus     = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		check("irq_n reset", 8'(irq_n), 8'h01);
		check("cart_rd reset", 8'(cart_rd), 8'h00);
		check("cart_wr reset", 8'(cart_wr), 8'h00);
		cart_and_ram_access();
		wram_bank_switch();
		joypad_press();
		irq_priority_ack();
		serial_transfer();
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== verilog/gb_system.sv ====
// system top joining the cpu bus, cartridge bus, interrupts, joypad, serial and ram
`timescale 1ns/100ps

module gb_system import gb_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       cgb_mode,
	input  gb_addr_t   cpu_addr,
	input  gb_data_t   cpu_do,
	input  logic       cpu_rd_n,
	input  logic       cpu_wr_n,
	input  logic       cpu_m1_n,
	input  logic       cpu_iorq_n,
	input  logic [7:0] joystick,
	input  logic       vblank_irq,
	input  logic       lcd_irq,
	input  logic       timer_irq,
	input  gb_data_t   cart_do,
	output gb_data_t   cpu_di,
	output logic       irq_n,
	output gb_addr_t   cart_addr,
	output gb_data_t   cart_di,
	output logic       cart_rd,
	output logic       cart_wr
);

	logic     joy_wr, sc_wr, if_wr, ie_wr, wram_wr, zpram_wr, svbk_wr;
	logic     irq_ack, serial_irq, joy_irq;
	gb_data_t irq_vec, joy_q, sc_q, wram_q, zpram_q;
	gb_irq_t  if_q, ie_q;

	// cartridge sees the cpu bus unchanged
	assign cart_addr = cpu_addr;
	assign cart_di   = cpu_do;

	gb_bus_decode u_decode (
		.cgb_mode (cgb_mode), .cpu_addr (cpu_addr), .cpu_rd_n (cpu_rd_n),
		.cpu_wr_n (cpu_wr_n), .irq_ack (irq_ack), .irq_vec (irq_vec),
		.if_q (if_q), .ie_q (ie_q), .joy_q (joy_q), .sc_q (sc_q),
		.wram_q (wram_q), .zpram_q (zpram_q), .cart_do (cart_do),
		.cpu_di (cpu_di), .cart_rd (cart_rd), .cart_wr (cart_wr),
		.joy_wr (joy_wr), .sc_wr (sc_wr), .if_wr (if_wr), .ie_wr (ie_wr),
		.wram_wr (wram_wr), .zpram_wr (zpram_wr), .svbk_wr (svbk_wr)
	);

	// source order matches IF bits, vblank in bit 0
	gb_irq_ctrl u_irq (
		.clk (clk), .reset (reset), .cpu_m1_n (cpu_m1_n), .cpu_iorq_n (cpu_iorq_n),
		.cpu_do (cpu_do), .if_wr (if_wr), .ie_wr (ie_wr),
		.src_pulse ({joy_irq, serial_irq, timer_irq, lcd_irq, vblank_irq}),
		.if_q (if_q), .ie_q (ie_q), .irq_n (irq_n), .irq_ack (irq_ack),
		.irq_vec (irq_vec)
	);

	gb_joypad u_joy (
		.clk (clk), .reset (reset), .joystick (joystick), .cpu_do (cpu_do),
		.joy_wr (joy_wr), .joy_q (joy_q), .joy_irq (joy_irq)
	);

	gb_serial u_serial (
		.clk (clk), .reset (reset), .cpu_do (cpu_do), .sc_wr (sc_wr),
		.sc_q (sc_q), .serial_irq (serial_irq)
	);

	gb_work_ram u_ram (
		.clk (clk), .reset (reset), .cpu_addr (cpu_addr), .cpu_do (cpu_do),
		.wram_wr (wram_wr), .zpram_wr (zpram_wr), .svbk_wr (svbk_wr),
		.wram_q (wram_q), .zpram_q (zpram_q)
	);

endmodule

// ==== verilog/gb_work_ram.sv ====
// banked work ram, zero page ram and the SVBK bank register
`timescale 1ns/100ps
`include "gb_defs.svh"

module gb_work_ram import gb_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  gb_addr_t cpu_addr,
	input  gb_data_t cpu_do,
	input  logic     wram_wr,
	input  logic     zpram_wr,
	input  logic     svbk_wr,
	output gb_data_t wram_q,
	output gb_data_t zpram_q
);

	gb_wbank_t     bank;       // 1..7
	gb_wram_addr_t wram_addr;

	// ------------------------------
	// svbk
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			bank <= 3'd1;
		end else if (svbk_wr) begin
			if (cpu_do[2:0] == 3'd0)
				bank <= 3'd1;          // bank 0 not selectable here
			else
				bank <= cpu_do[2:0];
		end
	end

	// lower 4k fixed to bank 0, upper 4k switched
	assign wram_addr = cpu_addr[12] ? {bank, cpu_addr[11:0]} : {3'b000, cpu_addr[11:0]};

	gb_spram #(
		.ADDR_W (`GB_WRAM_AW)
	) u_wram (
		.clk  (clk),
		.addr (wram_addr),
		.we   (wram_wr),
		.din  (cpu_do),
		.q    (wram_q)
	);

	// 127 bytes at ff80
	gb_spram #(
		.ADDR_W (`GB_ZPRAM_AW)
	) u_zpram (
		.clk  (clk),
		.addr (cpu_addr[`GB_ZPRAM_AW-1:0]),
		.we   (zpram_wr),
		.din  (cpu_do),
		.q    (zpram_q)
	);

	a_bank_nonzero: assert property (@(posedge clk) disable iff (reset)
		bank != 3'd0)
		else $error("work ram bank register holds 0");

endmodule

// ==== verilog/gb_serial.sv ====
// dummy serial port with SC control register, bit timer and completion interrupt
`timescale 1ns/100ps
`include "gb_defs.svh"

module gb_serial import gb_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  gb_data_t cpu_do,
	input  logic     sc_wr,
	output gb_data_t sc_q,
	output logic     serial_irq
);

	serial_state_t                state;
	logic                         sc_start;  // SC bit 7, transfer busy
	logic                         sc_clk;    // SC bit 0, internal clock
	logic [`GB_SERIAL_DIV_W-1:0]  div;
	logic [3:0]                   bit_cnt;   // bits left

	assign sc_q = {sc_start, 6'h3f, sc_clk};

	// ------------------------------
	// transfer fsm
	// ------------------------------
	always_ff @(posedge clk) begin
		serial_irq <= 1'b0;
		if (reset) begin
			state    <= SER_IDLE;
			sc_start <= 1'b0;
			sc_clk   <= 1'b0;
			div      <= '1;
			bit_cnt  <= '0;
		end else if (sc_wr) begin
			sc_start <= cpu_do[7];
			sc_clk   <= cpu_do[0];
			div      <= '1;
			bit_cnt  <= 4'(`GB_SERIAL_BITS);
			// external clock never arrives, so only internal clock runs
			state    <= (cpu_do[7] && cpu_do[0]) ? SER_SHIFT : SER_IDLE;
		end else begin
			case (state)
				SER_IDLE: begin
					div <= '1; // hold
				end
				SER_SHIFT: begin
					div <= div - 1'b1;
					if (div == '0) begin
						if (bit_cnt == '0) begin
							serial_irq <= 1'b1;   // done
							sc_start   <= 1'b0;
							state      <= SER_IDLE;
						end else begin
							bit_cnt <= bit_cnt - 1'b1;
						end
					end
				end
				default: state <= SER_IDLE;
			endcase
		end
	end

	a_irq_single: assert property (@(posedge clk) disable iff (reset)
		serial_irq |=> !serial_irq)
		else $error("serial_irq longer than one cycle");

endmodule

// ==== verilog/gb_joypad.sv ====
// joypad register P1 with button matrix and line-fall interrupt
`timescale 1ns/100ps

module gb_joypad import gb_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] joystick,  // active high buttons
	input  gb_data_t   cpu_do,
	input  logic       joy_wr,
	output gb_data_t   joy_q,
	output logic       joy_irq
);

	logic [1:0]    p54;              // P15, P14 select, low active
	gb_joy_lines_t dir_lines, btn_lines, lines;
	gb_joy_lines_t sync_1, sync_2;   // two-stage synchroniser
	gb_joy_lines_t lines_d;          // previous synced value

	// deselected group floats high
	assign dir_lines = ~joystick[3:0] | {4{p54[0]}}; // down up left right
	assign btn_lines = ~joystick[7:4] | {4{p54[1]}}; // start select b a
	assign lines     = dir_lines & btn_lines;
	assign joy_q     = {2'b11, p54, lines};

	always_ff @(posedge clk) begin
		if (reset) begin
			p54     <= 2'b00;
			sync_1  <= '1;
			sync_2  <= '1;
			lines_d <= '1;
			joy_irq <= 1'b0;
		end else begin
			if (joy_wr)
				p54 <= cpu_do[5:4];
			sync_1  <= lines;
			sync_2  <= sync_1;
			lines_d <= sync_2;
			joy_irq <= |(lines_d & ~sync_2); // any high to low
		end
	end

endmodule

// ==== verilog/gb_irq_ctrl.sv ====
// interrupt controller with IF/IE registers, priority vector and clear on acknowledge
`timescale 1ns/100ps
`include "gb_defs.svh"

module gb_irq_ctrl import gb_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     cpu_m1_n,
	input  logic     cpu_iorq_n,
	input  gb_data_t cpu_do,
	input  logic     if_wr,
	input  logic     ie_wr,
	input  gb_irq_t  src_pulse,  // one-cycle events
	output gb_irq_t  if_q,
	output gb_irq_t  ie_q,
	output logic     irq_n,
	output logic     irq_ack,
	output gb_data_t irq_vec
);

	logic    ack_d;     // ack one cycle ago
	logic    ack_fall;
	gb_irq_t pending;
	gb_irq_t clr_mask;  // highest priority pending bit

	// ------------------------------
	// request and vector
	// ------------------------------
	assign irq_ack  = !cpu_iorq_n && !cpu_m1_n;
	assign ack_fall = ack_d && !irq_ack;
	assign pending  = if_q & ie_q;
	assign irq_n    = pending == '0;

	// isolate lowest set bit, bit 0 is vblank and ranks first
	assign clr_mask = pending & (~pending + 1'b1);

	always_comb begin
		if (pending[0])      irq_vec = `GB_VEC_VBLANK;
		else if (pending[1]) irq_vec = `GB_VEC_LCD;
		else if (pending[2]) irq_vec = `GB_VEC_TIMER;
		else if (pending[3]) irq_vec = `GB_VEC_SERIAL;
		else if (pending[4]) irq_vec = `GB_VEC_JOY;
		else                 irq_vec = `GB_VEC_NONE;
	end

	// ------------------------------
	// flag and enable registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			if_q  <= '0;
			ie_q  <= '0;
			ack_d <= 1'b0;
		end else begin
			ack_d <= irq_ack;

			if (ie_wr)
				ie_q <= cpu_do[`GB_IRQ_N-1:0];

			// cpu write overrides both set and clear
			if (if_wr)
				if_q <= cpu_do[`GB_IRQ_N-1:0];
			else if (ack_fall)
				if_q <= (if_q & ~clr_mask) | src_pulse; // new event not lost
			else
				if_q <= if_q | src_pulse;
		end
	end

	// end of an ack drops exactly the serviced flag
	a_ack_clears_one: assert property (@(posedge clk) disable iff (reset)
		(ack_fall && !if_wr && (src_pulse == '0) && (pending != '0))
		|=> ($countones($past(if_q) ^ if_q) == 1))
		else $error("ack clear did not remove exactly one IF bit");

endmodule

// ==== verilog/gb_bus_decode.sv ====
// address decoder, per-target write strobes, cartridge strobes and cpu read mux
`timescale 1ns/100ps
`include "gb_defs.svh"

module gb_bus_decode import gb_pkg::*; (
	input  logic     cgb_mode,
	input  gb_addr_t cpu_addr,
	input  logic     cpu_rd_n,
	input  logic     cpu_wr_n,
	input  logic     irq_ack,
	input  gb_data_t irq_vec,
	input  gb_irq_t  if_q,
	input  gb_irq_t  ie_q,
	input  gb_data_t joy_q,
	input  gb_data_t sc_q,
	input  gb_data_t wram_q,
	input  gb_data_t zpram_q,
	input  gb_data_t cart_do,
	output gb_data_t cpu_di,
	output logic     cart_rd,
	output logic     cart_wr,
	output logic     joy_wr,
	output logic     sc_wr,
	output logic     if_wr,
	output logic     ie_wr,
	output logic     wram_wr,
	output logic     zpram_wr,
	output logic     svbk_wr
);

	// ------------------------------
	// region and register selects
	// ------------------------------
	logic sel_rom, sel_cram, sel_cart, sel_wram, sel_zpram;
	logic sel_joy, sel_sb, sel_sc, sel_if, sel_ie, sel_svbk;
	logic wr;
	logic [7:0] wr_vec;

	assign sel_rom   = !cpu_addr[15];                 // 0000-7fff
	assign sel_cram  = cpu_addr[15:13] == 3'b101;     // a000-bfff
	assign sel_cart  = sel_rom || sel_cram;
	assign sel_wram  = (cpu_addr >= `GB_WRAM_BASE) && (cpu_addr < 16'hfe00); // incl. echo
	assign sel_zpram = (cpu_addr >= `GB_ZPRAM_BASE) && (cpu_addr != `GB_ADDR_IE);

	assign sel_joy  = cpu_addr == `GB_ADDR_JOYP;
	assign sel_sb   = cpu_addr == `GB_ADDR_SB;
	assign sel_sc   = cpu_addr == `GB_ADDR_SC;
	assign sel_if   = cpu_addr == `GB_ADDR_IF;
	assign sel_ie   = cpu_addr == `GB_ADDR_IE;
	assign sel_svbk = cpu_addr == `GB_ADDR_SVBK;

	// write strobes, level while wr_n low
	assign wr       = !cpu_wr_n;
	assign joy_wr   = sel_joy && wr;
	assign sc_wr    = sel_sc && wr;
	assign if_wr    = sel_if && wr;
	assign ie_wr    = sel_ie && wr;
	assign wram_wr  = sel_wram && wr;
	assign zpram_wr = sel_zpram && wr;
	assign svbk_wr  = sel_svbk && wr && cgb_mode; // dmg has no svbk

	// cartridge pass-through
	assign cart_rd = sel_cart && !cpu_rd_n;
	assign cart_wr = sel_cart && wr;

	// ------------------------------
	// read mux, vector wins during ack
	// ------------------------------
	always_comb begin
		if (irq_ack)        cpu_di = irq_vec;
		else if (sel_joy)   cpu_di = joy_q;
		else if (sel_sb)    cpu_di = 8'hff;             // no real link partner
		else if (sel_sc)    cpu_di = sc_q;
		else if (sel_cart)  cpu_di = cart_do;
		else if (sel_wram)  cpu_di = wram_q;            // one cycle behind addr
		else if (sel_zpram) cpu_di = zpram_q;
		else if (sel_ie)    cpu_di = {3'b000, ie_q};
		else if (sel_if)    cpu_di = {3'b111, if_q};
		else                cpu_di = 8'hff;             // unmapped and svbk
	end

	// decode regions must never overlap on a write
	assign wr_vec = {joy_wr, sc_wr, if_wr, ie_wr, wram_wr, zpram_wr, svbk_wr, cart_wr};

	always_comb begin
		if (!$isunknown(wr_vec))
			a_wr_onehot: assert final ($onehot0(wr_vec))
				else $error("more than one write strobe active: %b", wr_vec);
	end

endmodule

// ==== verilog/gb_spram.sv ====
// single port ram with registered read, write-first
`timescale 1ns/100ps

module gb_spram import gb_pkg::*; #(
	parameter int ADDR_W = 7
) (
	input  logic              clk,
	input  logic [ADDR_W-1:0] addr,
	input  logic              we,
	input  gb_data_t          din,
	output gb_data_t          q
);

	gb_data_t mem [2**ADDR_W];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= din;
			q <= din; // new data straight through
		end else begin
			q <= mem[addr];
		end
	end

endmodule

// ==== verilog/gb_pkg.sv ====
// bus address and data types, interrupt mask, work ram address and bank, joypad lines, serial states
`include "gb_defs.svh"

package gb_pkg;

	// cpu bus
	typedef logic [15:0] gb_addr_t;
	typedef logic [7:0]  gb_data_t;

	// one bit per source: vblank, lcd, timer, serial, joypad (bit 0 first)
	typedef logic [`GB_IRQ_N-1:0] gb_irq_t;

	// work ram
	typedef logic [`GB_WRAM_AW-1:0] gb_wram_addr_t; // physical, bank in top bits
	typedef logic [2:0]             gb_wbank_t;     // svbk, 1..7

	typedef logic [3:0] gb_joy_lines_t; // P10..P13, active low

	// dummy serial port
	typedef enum logic {
		SER_IDLE,
		SER_SHIFT
	} serial_state_t;

endpackage

// ==== include/gb_defs.svh ====
// io register addresses, memory region bounds, unit widths and interrupt vectors
`ifndef GB_DEFS_SVH
`define GB_DEFS_SVH

// ------------------------------
// io registers
// ------------------------------
`define GB_ADDR_JOYP   16'hff00 // P1, joypad select and lines
`define GB_ADDR_SB     16'hff01 // serial data, reads back ff
`define GB_ADDR_SC     16'hff02 // serial control
`define GB_ADDR_IF     16'hff0f // interrupt flags
`define GB_ADDR_SVBK   16'hff70 // cgb work ram bank
`define GB_ADDR_IE     16'hffff // interrupt enable

// region bounds
`define GB_WRAM_BASE   16'hc000 // work ram, echo up to fdff
`define GB_ZPRAM_BASE  16'hff80 // zero page, up to fffe

// ------------------------------
// widths
// ------------------------------
`define GB_WRAM_AW      15 // 8 banks of 4k
`define GB_ZPRAM_AW     7
`define GB_SERIAL_DIV_W 9  // 512 clocks per bit
`define GB_SERIAL_BITS  8
`define GB_IRQ_N        5

// rst vectors, highest priority first
`define GB_VEC_VBLANK  8'h40
`define GB_VEC_LCD     8'h48
`define GB_VEC_TIMER   8'h50
`define GB_VEC_SERIAL  8'h58
`define GB_VEC_JOY     8'h60
`define GB_VEC_NONE    8'h55 // ack with nothing pending

`endif
